/* bench/lsu_tb.sv */
// testbench for the memory stage subsystem
// replays instructions from the test data file, answers apb transfers
// with listed wait states and read data, and checks every writeback in order

`timescale 1ns/10ps

`include "lsu_params.svh"

module lsu_tb;

	localparam int MAX_ITEMS = 128;

	logic                   clock;
	logic                   rstn;
	logic                   ex_valid_i;
	logic                   ex_ready_o;
	logic                   ex_rd_wen_i;
	logic [`LSU_REG_AW-1:0] ex_rd_i;
	logic [`LSU_XLEN-1:0]   ex_result_i;
	logic [`LSU_XLEN-1:0]   ex_store_data_i;
	logic [2:0]             ex_load_type_i;
	logic [1:0]             ex_store_type_i;
	logic                   psel_o;
	logic                   penable_o;
	logic                   pwrite_o;
	logic [`LSU_XLEN-1:0]   paddr_o;
	logic [`LSU_XLEN-1:0]   pwdata_o;
	logic [3:0]             pstrb_o;
	logic [`LSU_XLEN-1:0]   prdata_i;
	logic                   pready_i;
	logic                   wb_valid_o;
	logic                   wb_ready_i;
	logic [`LSU_REG_AW-1:0] wb_rd_o;
	logic                   wb_wen_o;
	logic [`LSU_XLEN-1:0]   wb_data_o;

	// one entry per data line
	logic        t_wen      [MAX_ITEMS];
	logic [4:0]  t_rd       [MAX_ITEMS];
	logic [31:0] t_result   [MAX_ITEMS];
	logic [31:0] t_sdata    [MAX_ITEMS];
	logic [2:0]  t_ld       [MAX_ITEMS];
	logic [1:0]  t_st       [MAX_ITEMS];
	logic [31:0] t_prdata   [MAX_ITEMS];
	int          t_waits    [MAX_ITEMS];
	logic [31:0] t_pwdata   [MAX_ITEMS];
	logic [3:0]  t_pstrb    [MAX_ITEMS];
	logic [4:0]  t_exp_rd   [MAX_ITEMS];
	logic        t_exp_wen  [MAX_ITEMS];
	logic [31:0] t_exp_data [MAX_ITEMS];

	int n_items  = 0;
	int wb_count = 0;
	// memory items in program order, the bus must see exactly these
	int apb_q[$];

	lsu_subsystem lsu_subsystem_inst (.*);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "run stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			abort_run($sformatf("mismatch on %s", name));
		end
	endtask

	task automatic load_testdata();
		int          fd;
		int          cnt;
		string       line;
		logic [31:0] f [0:12];
		fd = $fopen("bench/lsu_testdata.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open bench/lsu_testdata.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// skip comments and blank lines
				if (line.len() > 1 && line.getc(0) != "#") begin
					cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6],
						f[7], f[8], f[9], f[10], f[11], f[12]);
					if (cnt != 13 || n_items >= MAX_ITEMS) begin
						abort_run($sformatf("unreadable test data line: %s", line));
					end else begin
						t_wen[n_items]      = f[0][0];
						t_rd[n_items]       = f[1][4:0];
						t_result[n_items]   = f[2];
						t_sdata[n_items]    = f[3];
						t_ld[n_items]       = f[4][2:0];
						t_st[n_items]       = f[5][1:0];
						t_prdata[n_items]   = f[6];
						t_waits[n_items]    = f[7];
						t_pwdata[n_items]   = f[8];
						t_pstrb[n_items]    = f[9][3:0];
						t_exp_rd[n_items]   = f[10][4:0];
						t_exp_wen[n_items]  = f[11][0];
						t_exp_data[n_items] = f[12];
						if (f[4] != 0 || f[5] != 0) begin
							apb_q.push_back(n_items);
						end
						n_items++;
					end
				end
			end
			$fclose(fd);
			if (n_items == 0) begin
				abort_run("test data file holds no instructions");
			end
		end
	endtask

	task automatic drive_item(input int idx);
		ex_valid_i      = 1'b1;
		ex_rd_wen_i     = t_wen[idx];
		ex_rd_i         = t_rd[idx];
		ex_result_i     = t_result[idx];
		ex_store_data_i = t_sdata[idx];
		ex_load_type_i  = t_ld[idx];
		ex_store_type_i = t_st[idx];
	endtask

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	initial begin : main_seq
		rstn            = 1'b0;
		ex_valid_i      = 1'b0;
		ex_rd_wen_i     = 1'b0;
		ex_rd_i         = '0;
		ex_result_i     = '0;
		ex_store_data_i = '0;
		ex_load_type_i  = '0;
		ex_store_type_i = '0;
		prdata_i        = '0;
		pready_i        = 1'b0;
		load_testdata();
		repeat (2) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
		// idle state straight after reset
		check_value("psel_o", psel_o, 0);
		check_value("penable_o", penable_o, 0);
		check_value("wb_valid_o", wb_valid_o, 0);
		check_value("ex_ready_o", ex_ready_o, 1);
		for (int i = 0; i < n_items; i++) begin
			@(negedge clock);
			drive_item(i);
			do @(posedge clock); while (!ex_ready_o);
		end
		@(negedge clock);
		ex_valid_i = 1'b0;
		wait (wb_count == n_items);
		repeat (4) @(negedge clock);
		check_value("apb transfers left", apb_q.size(), 0);
		check_value("wb_valid_o", wb_valid_o, 0);
		$display("PASS: all tests");
		$finish;
	end

	// apb slave, answers in order and checks the request side
	initial begin : apb_slave
		int          idx;
		int          waits_left;
		logic [31:0] cap_addr;
		logic [31:0] cap_wdata;
		logic [3:0]  cap_strb;
		logic        cap_write;
		forever begin
			@(negedge clock);
			if (penable_o && !psel_o) begin
				abort_run("penable_o is high while psel_o is low");
			end
			if (psel_o && !penable_o) begin
				if (apb_q.size() == 0) begin
					abort_run("apb transfer started for an item with no load or store");
				end
				idx = apb_q.pop_front();
				check_value("paddr_o", paddr_o, t_result[idx]);
				check_value("pwrite_o", pwrite_o, t_st[idx] != 0);
				if (pwrite_o) begin
					check_value("pwdata_o", pwdata_o, t_pwdata[idx]);
				end
				check_value("pstrb_o", pstrb_o, t_pstrb[idx]);
				cap_addr   = paddr_o;
				cap_wdata  = pwdata_o;
				cap_strb   = pstrb_o;
				cap_write  = pwrite_o;
				waits_left = t_waits[idx];
				prdata_i   = t_prdata[idx];
				pready_i   = 1'b0;
			end else if (psel_o && penable_o) begin
				// request must hold through every wait state
				check_value("paddr_o", paddr_o, cap_addr);
				check_value("pwdata_o", pwdata_o, cap_wdata);
				check_value("pstrb_o", pstrb_o, cap_strb);
				check_value("pwrite_o", pwrite_o, cap_write);
				if (waits_left == 0) begin
					pready_i = 1'b1;
				end else begin
					waits_left--;
					pready_i = 1'b0;
				end
			end else begin
				pready_i = 1'b0;
			end
		end
	end

	// writeback scoreboard, file order is program order
	initial begin : wb_monitor
		forever begin
			@(posedge clock);
			if (rstn && wb_valid_o && wb_ready_i) begin
				if (wb_count >= n_items) begin
					abort_run("writeback seen after every instruction had retired");
				end
				check_value("wb_rd_o", wb_rd_o, t_exp_rd[wb_count]);
				check_value("wb_wen_o", wb_wen_o, t_exp_wen[wb_count]);
				check_value("wb_data_o", wb_data_o, t_exp_data[wb_count]);
				wb_count++;
			end
		end
	end

	// random stalls from writeback
	initial begin : wb_backpressure
		int hold;
		void'($urandom(32'h968a_be91));
		wb_ready_i = 1'b0;
		forever begin
			hold = $urandom % 4 + 1;
			repeat (hold) begin
				@(negedge clock);
				wb_ready_i = 1'b1;
			end
			hold = $urandom % 4;
			repeat (hold) begin
				@(negedge clock);
				wb_ready_i = 1'b0;
			end
		end
	end

	initial begin : watchdog
		wait (n_items > 0);
		repeat ((n_items + 2) * 40) @(posedge clock);
		abort_run($sformatf("timeout: only %0d of %0d writebacks arrived",
			wb_count, n_items));
	end

endmodule

/* bench/lsu_testdata.txt */
# one instruction per line, hex: wen rd result store_data ld st prdata waits
#   then expected: pwdata pstrb wb_rd wb_wen wb_data
# ld 0 none 1 lb 2 lh 3 lw 4 lbu 5 lhu, st 0 none 1 sb 2 sh 3 sw
1 01 00000011 00000000 0 0 00000000 0 00000000 0 01 1 00000011
1 02 deadbeef 00000000 0 0 00000000 0 00000000 0 02 1 deadbeef
0 03 00000005 00000000 0 0 00000000 0 00000000 0 03 0 00000005
1 1f 80000000 00000000 0 0 00000000 0 00000000 0 1f 1 80000000
1 00 12345678 00000000 0 0 00000000 0 00000000 0 00 1 12345678
1 0a ffffffff 00000000 0 0 00000000 0 00000000 0 0a 1 ffffffff
0 00 80000000 a1b2c3d4 0 1 00000000 0 a1b2c3d4 1 00 0 80000000
0 00 80000001 a1b2c3d4 0 1 00000000 1 b2c3d400 2 00 0 80000001
0 00 80000002 a1b2c3d4 0 1 00000000 2 c3d40000 4 00 0 80000002
0 00 80000003 a1b2c3d4 0 1 00000000 3 d4000000 8 00 0 80000003
0 00 80000010 a1b2c3d4 0 2 00000000 4 a1b2c3d4 3 00 0 80000010
0 00 80000011 a1b2c3d4 0 2 00000000 5 b2c3d400 6 00 0 80000011
0 00 80000012 a1b2c3d4 0 2 00000000 0 c3d40000 c 00 0 80000012
0 00 80000013 a1b2c3d4 0 2 00000000 1 d4000000 8 00 0 80000013
0 00 80000020 a1b2c3d4 0 3 00000000 2 a1b2c3d4 f 00 0 80000020
0 00 80000021 a1b2c3d4 0 3 00000000 3 b2c3d400 e 00 0 80000021
0 00 80000022 a1b2c3d4 0 3 00000000 4 c3d40000 c 00 0 80000022
0 00 80000023 a1b2c3d4 0 3 00000000 5 d4000000 8 00 0 80000023
1 05 00000042 00000000 0 0 00000000 0 00000000 0 05 1 00000042
0 00 10000003 a1b2c3d4 0 1 00000000 0 a1b2c3d4 1 00 0 10000003
0 00 10000002 a1b2c3d4 0 2 00000000 1 a1b2c3d4 3 00 0 10000002
0 00 10000005 a1b2c3d4 0 3 00000000 2 a1b2c3d4 f 00 0 10000005
0 00 10000fff a1b2c3d4 0 1 00000000 3 a1b2c3d4 1 00 0 10000fff
0 00 10001001 a1b2c3d4 0 1 00000000 0 b2c3d400 2 00 0 10001001
0 00 0fffffff a1b2c3d4 0 1 00000000 1 d4000000 8 00 0 0fffffff
1 07 80000030 0000beef 0 2 00000000 0 0000beef 3 07 1 80000030
1 06 80000100 00000000 1 0 8a7b9c6d 0 00000000 0 06 1 0000006d
1 07 80000101 00000000 1 0 8a7b9c6d 1 00000000 0 07 1 ffffff9c
1 08 80000102 00000000 1 0 8a7b9c6d 2 00000000 0 08 1 0000007b
1 09 80000103 00000000 1 0 8a7b9c6d 3 00000000 0 09 1 ffffff8a
1 0a 80000104 00000000 2 0 8a7b9c6d 4 00000000 0 0a 1 ffff9c6d
1 0b 80000105 00000000 2 0 8a7b9c6d 5 00000000 0 0b 1 00007b9c
1 0c 80000106 00000000 2 0 8a7b9c6d 0 00000000 0 0c 1 ffff8a7b
1 0d 80000107 00000000 2 0 8a7b9c6d 1 00000000 0 0d 1 0000008a
1 0e 80000108 00000000 3 0 8a7b9c6d 2 00000000 0 0e 1 8a7b9c6d
1 0f 80000109 00000000 3 0 8a7b9c6d 3 00000000 0 0f 1 008a7b9c
1 10 8000010a 00000000 3 0 8a7b9c6d 4 00000000 0 10 1 00008a7b
1 11 8000010b 00000000 3 0 8a7b9c6d 5 00000000 0 11 1 0000008a
1 12 8000010c 00000000 4 0 8a7b9c6d 0 00000000 0 12 1 0000006d
1 13 8000010d 00000000 4 0 8a7b9c6d 1 00000000 0 13 1 0000009c
1 14 8000010e 00000000 4 0 8a7b9c6d 2 00000000 0 14 1 0000007b
1 15 8000010f 00000000 4 0 8a7b9c6d 3 00000000 0 15 1 0000008a
1 16 80000110 00000000 5 0 8a7b9c6d 4 00000000 0 16 1 00009c6d
1 17 80000111 00000000 5 0 8a7b9c6d 5 00000000 0 17 1 00007b9c
1 18 80000112 00000000 5 0 8a7b9c6d 0 00000000 0 18 1 00008a7b
1 19 80000113 00000000 5 0 8a7b9c6d 1 00000000 0 19 1 0000008a
1 1a 0000abcd 00000000 0 0 00000000 0 00000000 0 1a 1 0000abcd
1 1b 10000003 00000000 1 0 123456f0 2 00000000 0 1b 1 fffffff0
1 1c 10000003 00000000 4 0 123456f0 3 00000000 0 1c 1 000000f0
1 1d 10000002 00000000 2 0 000080f0 4 00000000 0 1d 1 ffff80f0
1 1e 10000001 00000000 5 0 123456f0 5 00000000 0 1e 1 000056f0
1 01 10000000 00000000 3 0 123456f0 0 00000000 0 01 1 123456f0
1 02 10000fff 00000000 1 0 000000ff 1 00000000 0 02 1 ffffffff
0 03 80000200 00000000 3 0 cafef00d 0 00000000 0 03 0 cafef00d
1 04 00000001 00000000 0 0 00000000 0 00000000 0 04 1 00000001
1 05 00000002 00000000 0 0 00000000 0 00000000 0 05 1 00000002

/* sim.f */
+incdir+source
source/lsu_pkg.sv
source/stage_if.sv
source/pipe_stage_reg.sv
source/lsu_access.sv
source/lsu_subsystem.sv
bench/lsu_tb.sv

/* source/lsu_access.sv */
// memory access unit
// runs one apb transfer per load or store and passes other items through,
// stores get byte lane shifting and strobes, loads get lane extraction
// and sign or zero extension

`timescale 1ns/10ps

`include "lsu_params.svh"

module lsu_access (
	input  logic                   clock,
	input  logic                   rstn,
	stage_if.consumer              req_i,
	stage_if.producer              rsp_o,
	output logic                   psel_o,
	output logic                   penable_o,
	output logic                   pwrite_o,
	output logic [`LSU_XLEN-1:0]   paddr_o,
	output logic [`LSU_XLEN-1:0]   pwdata_o,
	output logic [`LSU_XLEN/8-1:0] pstrb_o,
	input  logic [`LSU_XLEN-1:0]   prdata_i,
	input  logic                   pready_i
);

	import lsu_pkg::*;

	localparam int STRB_W = `LSU_XLEN / 8;
	localparam int LANE_W = $clog2(STRB_W);

	typedef enum logic [1:0] {
		S_IDLE,
		S_SETUP,
		S_ACCESS
	} state_e;

	state_e              state_q;
	state_e              state_d;
	ex_to_mem_t          req;
	mem_to_wb_t          rsp;
	logic                is_load;
	logic                is_store;
	logic                mem_op;
	logic                in_io;
	logic [LANE_W-1:0]   lane;
	logic [STRB_W-1:0]   strb_raw;
	logic [STRB_W-1:0]   st_strb;
	logic [`LSU_XLEN-1:0] st_data;
	logic [`LSU_XLEN-1:0] ld_shift;
	logic [`LSU_XLEN-1:0] ld_data;
	logic                pass_through;
	logic                complete;

	// in_reg holds the item for the whole transfer
	assign req = req_i.payload;

	assign is_load  = (req.load_type != LD_NONE);
	assign is_store = (req.store_type != ST_NONE);
	assign mem_op   = is_load || is_store;

	// peripherals take unshifted data on lane 0
	assign in_io = (req.result >= `LSU_IO_LO) && (req.result <= `LSU_IO_HI);
	assign lane  = in_io ? '0 : req.result[LANE_W-1:0];

	// fsm
	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE: begin
				// out_reg must have room before the bus is touched
				if (req_i.valid && mem_op && rsp_o.ready) begin
					state_d = S_SETUP;
				end
			end
			S_SETUP: begin
				state_d = S_ACCESS;
			end
			S_ACCESS: begin
				if (pready_i) begin
					state_d = S_IDLE;
				end
			end
			default: begin
				state_d = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state_q <= S_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// store formatting
	always_comb begin
		case (req.store_type)
			ST_SB:   strb_raw = STRB_W'(4'b0001);
			ST_SH:   strb_raw = STRB_W'(4'b0011);
			ST_SW:   strb_raw = STRB_W'(4'b1111);
			default: strb_raw = '0;
		endcase
	end

	assign st_strb = strb_raw << lane;
	assign st_data = req.store_data << {lane, 3'b000};

	// apb master outputs decoded from state
	assign psel_o    = (state_q != S_IDLE);
	assign penable_o = (state_q == S_ACCESS);
	assign pwrite_o  = psel_o && is_store;
	assign paddr_o   = req.result;
	assign pwdata_o  = st_data;
	assign pstrb_o   = pwrite_o ? st_strb : '0;

	// load extraction then extension by size
	assign ld_shift = prdata_i >> {lane, 3'b000};

	always_comb begin
		case (req.load_type)
			LD_LB:   ld_data = {{(`LSU_XLEN-8){ld_shift[7]}}, ld_shift[7:0]};
			LD_LH:   ld_data = {{(`LSU_XLEN-16){ld_shift[15]}}, ld_shift[15:0]};
			LD_LBU:  ld_data = {{(`LSU_XLEN-8){1'b0}}, ld_shift[7:0]};
			LD_LHU:  ld_data = {{(`LSU_XLEN-16){1'b0}}, ld_shift[15:0]};
			default: ld_data = ld_shift;
		endcase
	end

	// handoff to out_reg and release of in_reg on the same edge
	assign pass_through = (state_q == S_IDLE) && req_i.valid && !mem_op;
	assign complete     = (state_q == S_ACCESS) && pready_i;

	assign rsp_o.valid = pass_through || complete;
	assign req_i.ready = rsp_o.ready && (((state_q == S_IDLE) && !mem_op) || complete);

	assign rsp.rd_wen = req.rd_wen;
	assign rsp.rd     = req.rd;
	assign rsp.data   = is_load ? ld_data : req.result;

	assign rsp_o.payload = rsp;

	// bus request held from setup through the last wait state
	a_apb_hold: assert property (
		@(posedge clock) disable iff (!rstn)
		(psel_o && !(penable_o && pready_i)) |=>
		(psel_o && $stable(paddr_o) && $stable(pwrite_o) &&
		 $stable(pwdata_o) && $stable(pstrb_o))
	) else $error("apb request changed before pready");

	// out_reg takes the result on the completion edge
	a_apb_enable: assert property (
		@(posedge clock) disable iff (!rstn)
		(penable_o && pready_i) |-> rsp_o.ready
	) else $error("apb transfer completed while out_reg had no room");

endmodule

/* source/lsu_params.svh */
// lsu parameter macros
// data width, register index width and the peripheral address window
// shared by the package, the access unit and the subsystem top

`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// data and address width of the memory stage
`define LSU_XLEN 32

// register file index width
`define LSU_REG_AW 5

// peripheral window, both bounds inclusive
// devices in here see byte and half data on lane 0,
// everything else uses the lane picked by addr[1:0]
`define LSU_IO_LO 32'h1000_0000
`define LSU_IO_HI 32'h1000_0fff

`endif

/* source/lsu_pkg.sv */
// lsu package
// load/store type encodings and the payload bundles that move
// between execute, memory access and writeback

`include "lsu_params.svh"

package lsu_pkg;

	// load size and extension, 0 means no load
	typedef enum logic [2:0] {
		LD_NONE = 3'd0,
		LD_LB   = 3'd1,
		LD_LH   = 3'd2,
		LD_LW   = 3'd3,
		LD_LBU  = 3'd4,
		LD_LHU  = 3'd5
	} load_type_e;

	// store size, 0 means no store
	typedef enum logic [1:0] {
		ST_NONE = 2'd0,
		ST_SB   = 2'd1,
		ST_SH   = 2'd2,
		ST_SW   = 2'd3
	} store_type_e;

	// bundle registered from the execute stage
	typedef struct packed {
		logic                   rd_wen;
		logic [`LSU_REG_AW-1:0] rd;
		// alu result, doubles as the memory address
		logic [`LSU_XLEN-1:0]   result;
		// register value for stores, not yet lane shifted
		logic [`LSU_XLEN-1:0]   store_data;
		load_type_e             load_type;
		store_type_e            store_type;
	} ex_to_mem_t;

	// bundle handed to writeback
	typedef struct packed {
		logic                   rd_wen;
		logic [`LSU_REG_AW-1:0] rd;
		// loaded value or pass-through alu result
		logic [`LSU_XLEN-1:0]   data;
	} mem_to_wb_t;

endpackage

/* source/lsu_subsystem.sv */
// memory stage subsystem top
// execute bundle enters an input register, goes through the apb access
// unit and leaves through an output register toward writeback

`timescale 1ns/10ps

`include "lsu_params.svh"

module lsu_subsystem (
	input  logic                   clock,
	input  logic                   rstn,
	// execute side
	input  logic                   ex_valid_i,
	output logic                   ex_ready_o,
	input  logic                   ex_rd_wen_i,
	input  logic [`LSU_REG_AW-1:0] ex_rd_i,
	input  logic [`LSU_XLEN-1:0]   ex_result_i,
	input  logic [`LSU_XLEN-1:0]   ex_store_data_i,
	input  logic [$bits(lsu_pkg::load_type_e)-1:0]  ex_load_type_i,
	input  logic [$bits(lsu_pkg::store_type_e)-1:0] ex_store_type_i,
	// apb master
	output logic                   psel_o,
	output logic                   penable_o,
	output logic                   pwrite_o,
	output logic [`LSU_XLEN-1:0]   paddr_o,
	output logic [`LSU_XLEN-1:0]   pwdata_o,
	output logic [`LSU_XLEN/8-1:0] pstrb_o,
	input  logic [`LSU_XLEN-1:0]   prdata_i,
	input  logic                   pready_i,
	// writeback side
	output logic                   wb_valid_o,
	input  logic                   wb_ready_i,
	output logic [`LSU_REG_AW-1:0] wb_rd_o,
	output logic                   wb_wen_o,
	output logic [`LSU_XLEN-1:0]   wb_data_o
);

	import lsu_pkg::*;

	// boundary links to the plain ports
	stage_if #(.payload_t(ex_to_mem_t)) ex_side ();
	stage_if #(.payload_t(mem_to_wb_t)) wb_side ();

	// internal links
	stage_if #(.payload_t(ex_to_mem_t)) in_link ();
	stage_if #(.payload_t(mem_to_wb_t)) out_link ();

	// pack execute fields
	assign ex_side.valid   = ex_valid_i;
	assign ex_side.payload = '{
		rd_wen:     ex_rd_wen_i,
		rd:         ex_rd_i,
		result:     ex_result_i,
		store_data: ex_store_data_i,
		load_type:  load_type_e'(ex_load_type_i),
		store_type: store_type_e'(ex_store_type_i)
	};
	assign ex_ready_o = ex_side.ready;

	pipe_stage_reg #(.payload_t(ex_to_mem_t)) in_reg (
		.clock  (clock),
		.rstn   (rstn),
		.up_i   (ex_side.consumer),
		.down_o (in_link.producer)
	);

	lsu_access lsu_access_inst (
		.clock     (clock),
		.rstn      (rstn),
		.req_i     (in_link.consumer),
		.rsp_o     (out_link.producer),
		.psel_o    (psel_o),
		.penable_o (penable_o),
		.pwrite_o  (pwrite_o),
		.paddr_o   (paddr_o),
		.pwdata_o  (pwdata_o),
		.pstrb_o   (pstrb_o),
		.prdata_i  (prdata_i),
		.pready_i  (pready_i)
	);

	pipe_stage_reg #(.payload_t(mem_to_wb_t)) out_reg (
		.clock  (clock),
		.rstn   (rstn),
		.up_i   (out_link.consumer),
		.down_o (wb_side.producer)
	);

	// unpack writeback fields
	assign wb_valid_o    = wb_side.valid;
	assign wb_side.ready = wb_ready_i;
	assign wb_rd_o       = wb_side.payload.rd;
	assign wb_wen_o      = wb_side.payload.rd_wen;
	assign wb_data_o     = wb_side.payload.data;

endmodule

/* source/pipe_stage_reg.sv */
// pipeline stage register
// one-entry valid/allowin register for any payload type,
// stalls in place while the downstream side holds off

`timescale 1ns/10ps

module pipe_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic      clock,
	input  logic      rstn,
	stage_if.consumer up_i,
	stage_if.producer down_o
);

	logic     valid_q;
	payload_t data_q;

	// allowin when empty or when the held item leaves this cycle
	assign up_i.ready = !valid_q || down_o.ready;

	assign down_o.valid   = valid_q;
	assign down_o.payload = data_q;

	always_ff @(posedge clock) begin
		if (!rstn) begin
			valid_q <= 1'b0;
		end else if (up_i.ready) begin
			// refill, or drop to empty after a drain
			valid_q <= up_i.valid;
		end
	end

	// payload only
	always_ff @(posedge clock) begin
		if (up_i.valid && up_i.ready) begin
			data_q <= up_i.payload;
		end
	end

	// a refused upstream item must stay offered and unchanged
	a_hold_stable: assert property (
		@(posedge clock) disable iff (!rstn)
		(up_i.valid && !up_i.ready) |=>
		(up_i.valid && $stable(up_i.payload))
	) else $error("upstream payload changed under back-pressure");

endmodule

/* source/stage_if.sv */
// pipeline stage link
// valid/ready handshake carrying one payload of any type,
// a beat moves on a clock edge where valid and ready are both high

`timescale 1ns/10ps

interface stage_if #(
	parameter type payload_t = logic
) ();

	// producer holds these until the beat is taken
	logic     valid;
	payload_t payload;

	// consumer allowin
	logic     ready;

	modport producer (
		output valid,
		output payload,
		input  ready
	);

	modport consumer (
		input  valid,
		input  payload,
		output ready
	);

endinterface
